// File: compile.f
net_pkg.sv
power_up_timer.sv
lease_timer.sv
link_fsm.sv
tx_arbiter.sv
udp_dest_select.sv
network_top.sv
tb_network.sv

// File: lease_timer.sv
// countdown timer for dhcp lease renewal and the retransmit delay
`timescale 1ns/1ps

module lease_timer import net_pkg::*; (
  input  logic       tx_clock,
  input  logic       rst_n,
  input  logic       load,
  input  renew_cnt_t load_value,
  input  logic       count_enable,
  output logic       expired
);

  renew_cnt_t count;

  // load wins over counting
  // stops at zero, never wraps
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (count_enable && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  assign expired = (count == '0);

endmodule

// File: link_fsm.sv
// address acquisition FSM covering phy bring-up, static ip, dhcp retries and apipa fallback
`timescale 1ns/1ps

module link_fsm import net_pkg::*; #(
  parameter int unsigned TICKS_PER_SECOND  = 2_500_000,
  parameter int unsigned SETTLE_TICKS      = 250_000,
  parameter int unsigned RETRY_DELAY_TICKS = 131072
) (
  input  logic       tx_clock,
  input  logic       rst_n,
  input  logic       config_ready,
  input  logic       phy_connected,
  input  ip_addr_t   static_ip,
  input  mac_addr_t  local_mac,
  input  logic       dhcp_success,
  input  ip_addr_t   ip_accept,
  input  lease_t     lease,
  output net_state_t state,
  output ip_addr_t   local_ip,
  output logic       phy_init_request,
  output logic       dhcp_tx_enable,
  output logic       dhcp_rx_enable,
  output logic       dhcp_phase,
  output logic       dhcp_timeout,
  output logic       static_ip_assigned
);

  logic [31:0] settle_cnt;
  // ticks left in the current dhcp second
  logic [31:0] dhcp_timer;
  dhcp_sec_t   dhcp_seconds;
  logic        link_lost;
  logic        second_done;
  logic        retry_due;
  logic        lease_load;
  renew_cnt_t  lease_load_value;
  renew_cnt_t  lease_ticks;
  logic        lease_expired;
  ip_addr_t    apipa_ip;

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  assign static_ip_assigned = (static_ip != '1) && (static_ip != '0);
  assign apipa_ip           = {APIPA_PREFIX, local_mac[15:0]};
  assign phy_init_request   = (state == ST_PHY_INIT);
  assign dhcp_phase         = (state == ST_DHCP_REQUEST) || (state == ST_DHCP);
  assign dhcp_timeout       = (dhcp_seconds == DHCP_GIVE_UP_SEC);

  // any state past connect falls back when the link drops
  assign link_lost   = (state > ST_PHY_CONNECT) && !phy_connected;
  assign second_done = (state == ST_DHCP) && (dhcp_timer == '0);
  // retransmit discover at 1, 3 and 7 seconds, old count is 0, 2, 6
  assign retry_due   = second_done &&
                       ((dhcp_seconds == 4'd0) || (dhcp_seconds == 4'd2) ||
                        (dhcp_seconds == 4'd6));

  // half the lease in ticks, default lease if server sent none
  assign lease_ticks = (lease == '0) ?
                       renew_cnt_t'(DEFAULT_LEASE_SEC) * renew_cnt_t'(TICKS_PER_SECOND) :
                       (renew_cnt_t'(lease) * renew_cnt_t'(TICKS_PER_SECOND)) >> 1;

  // timer loaded only on the way into renew
  assign lease_load       = !link_lost && (state == ST_DHCP) && (dhcp_success || retry_due);
  assign lease_load_value = dhcp_success ? lease_ticks : renew_cnt_t'(RETRY_DELAY_TICKS);

  lease_timer u_lease_timer (
    .tx_clock     (tx_clock),
    .rst_n        (rst_n),
    .load         (lease_load),
    .load_value   (lease_load_value),
    .count_enable (state == ST_DHCP_RENEW),
    .expired      (lease_expired)
  );

  // ------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state          <= ST_START;
      local_ip       <= '0;
      settle_cnt     <= '0;
      dhcp_timer     <= '0;
      dhcp_seconds   <= '0;
      dhcp_tx_enable <= 1'b0;
      dhcp_rx_enable <= 1'b0;
    end else begin
      // tx enable is a single pulse from the request state
      dhcp_tx_enable <= 1'b0;
      if (link_lost) begin
        state <= ST_PHY_CONNECT;
      end else begin
        case (state)
          ST_START:        state <= ST_CONFIG_START;
          ST_CONFIG_START: state <= ST_CONFIG_WAIT;
          // config data valid, pick up static ip
          ST_CONFIG_WAIT: begin
            if (config_ready) begin
              local_ip     <= static_ip;
              dhcp_timer   <= TICKS_PER_SECOND;
              dhcp_seconds <= '0;
              state        <= ST_PHY_INIT;
            end
          end
          ST_PHY_INIT:     state <= ST_PHY_CONNECT;
          ST_PHY_CONNECT: begin
            if (phy_connected) begin
              settle_cnt <= SETTLE_TICKS;
              state      <= ST_PHY_SETTLE;
            end
          end
          // leaves on the zero count, SETTLE_TICKS+1 cycles
          ST_PHY_SETTLE: begin
            if (settle_cnt == '0) begin
              if (static_ip_assigned) begin
                state <= ST_RUNNING;
              end else begin
                // dhcp needs 0.0.0.0
                local_ip <= '0;
                state    <= ST_DHCP_REQUEST;
              end
            end else begin
              settle_cnt <= settle_cnt - 1'b1;
            end
          end
          ST_DHCP_REQUEST: begin
            dhcp_tx_enable <= 1'b1;
            dhcp_rx_enable <= 1'b1;
            state          <= ST_DHCP;
          end
          // reply beats the seconds timer
          ST_DHCP: begin
            if (dhcp_success) begin
              local_ip     <= ip_accept;
              dhcp_timer   <= TICKS_PER_SECOND;
              dhcp_seconds <= '0;
              state        <= ST_DHCP_RENEW;
            end else if (second_done) begin
              dhcp_timer   <= TICKS_PER_SECOND;
              dhcp_seconds <= dhcp_seconds + 1'b1;
              if (retry_due) begin
                state <= ST_DHCP_RENEW;
              end else if (dhcp_seconds == DHCP_GIVE_UP_SEC - 1'b1) begin
                // no offer in 15 s, link-local address
                local_ip <= apipa_ip;
                state    <= ST_RUNNING;
              end
            end else begin
              dhcp_timer <= dhcp_timer - 1'b1;
            end
          end
          ST_DHCP_RENEW: begin
            dhcp_rx_enable <= 1'b0;
            if (lease_expired) begin
              state <= ST_DHCP_REQUEST;
            end
          end
          ST_RUNNING:      dhcp_rx_enable <= 1'b0;
          default:         state <= ST_START;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_state_legal: assert property (
    @(posedge tx_clock) disable iff (!rst_n)
    !$isunknown(state) && (state <= ST_RUNNING)
  );

  // dhcp engine sees one request strobe per discover
  a_dhcp_tx_pulse: assert property (
    @(posedge tx_clock) disable iff (!rst_n)
    dhcp_tx_enable |=> !dhcp_tx_enable
  );

endmodule

// File: net_pkg.sv
// network core package with address, port and timer types plus the state encodings
package net_pkg;

  // ------------------------------------------------------------
  // widths with a meaning
  // ------------------------------------------------------------
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] udp_port_t;
  // lease in seconds, as handed over by the dhcp engine
  typedef logic [31:0] lease_t;
  // renewal countdown in ticks
  typedef logic [37:0] renew_cnt_t;
  typedef logic [3:0]  dhcp_sec_t;

  // address acquisition states
  typedef enum logic [3:0] {
    ST_START        = 4'd0,
    ST_CONFIG_START = 4'd1,
    ST_CONFIG_WAIT  = 4'd2,
    ST_PHY_INIT     = 4'd3,
    ST_PHY_CONNECT  = 4'd4,
    ST_PHY_SETTLE   = 4'd5,
    ST_DHCP_REQUEST = 4'd6,
    ST_DHCP         = 4'd7,
    ST_DHCP_RENEW   = 4'd8,
    ST_RUNNING      = 4'd9
  } net_state_t;

  // frame source on the shared transmit path
  typedef enum logic [1:0] {
    PT_ARP  = 2'd0,
    PT_ICMP = 2'd1,
    PT_DHCP = 2'd2,
    PT_UDP  = 2'd3
  } tx_proto_t;

  // ------------------------------------------------------------
  // protocol constants
  // ------------------------------------------------------------
  localparam udp_port_t   DHCP_CLIENT_PORT  = 16'd68;
  localparam udp_port_t   DATA_CLIENT_PORT  = 16'd1024;
  // 169.254 link-local prefix
  localparam logic [15:0] APIPA_PREFIX      = {8'd169, 8'd254};
  // 12 hours when the server sends no lease
  localparam lease_t      DEFAULT_LEASE_SEC = 32'd43200;
  localparam dhcp_sec_t   DHCP_GIVE_UP_SEC  = 4'd15;

endpackage

// File: network_top.sv
// network control core top level tying power-up, address FSM, tx arbiter and destination mux
`timescale 1ns/1ps

module network_top import net_pkg::*; #(
  parameter int unsigned TICKS_PER_SECOND  = 2_500_000,
  parameter int unsigned SETTLE_TICKS      = 250_000,
  parameter int unsigned RETRY_DELAY_TICKS = 131072,
  parameter int          POWER_UP_BITS     = 15,
  parameter mac_addr_t   MAC_BASE          = 48'h02_A0_5D_00_10_20
) (
  input  logic       tx_clock,
  input  logic       rst_n,
  input  logic       macbit,
  // phy and dhcp engine results
  input  logic       phy_connected,
  input  ip_addr_t   static_ip,
  input  logic       dhcp_success,
  input  ip_addr_t   ip_accept,
  input  lease_t     lease,
  // transmit requests
  input  logic       arp_tx_request,
  input  logic       icmp_tx_request,
  input  logic       dhcp_tx_request,
  input  logic       udp_tx_request,
  input  logic       link_tx_active,
  // udp destinations
  input  logic       run,
  input  ip_addr_t   live_ip,
  input  mac_addr_t  live_mac,
  input  udp_port_t  live_port,
  input  ip_addr_t   dhcp_ip,
  input  mac_addr_t  dhcp_mac,
  input  udp_port_t  dhcp_port,
  output logic       phy_reset_n,
  output logic       config_ready,
  output net_state_t network_state,
  output ip_addr_t   local_ip,
  output mac_addr_t  local_mac,
  output logic       phy_init_request,
  output logic       dhcp_tx_enable,
  output logic       dhcp_rx_enable,
  output logic       dhcp_phase,
  output logic       dhcp_timeout,
  output logic       static_ip_assigned,
  output tx_proto_t  tx_protocol,
  output logic       arp_tx_enable,
  output logic       icmp_tx_enable,
  output logic       udp_tx_enable,
  output ip_addr_t   dest_ip,
  output mac_addr_t  dest_mac,
  output udp_port_t  dest_port,
  output udp_port_t  local_port
);

  // board strap flips bit 1 so two boards differ
  assign local_mac = {MAC_BASE[47:2], ~macbit, MAC_BASE[0]};

  // ------------------------------------------------------------
  // bring-up and addressing
  // ------------------------------------------------------------
  power_up_timer #(
    .POWER_UP_BITS (POWER_UP_BITS)
  ) u_power_up_timer (
    .tx_clock     (tx_clock),
    .rst_n        (rst_n),
    .phy_reset_n  (phy_reset_n),
    .config_ready (config_ready)
  );

  link_fsm #(
    .TICKS_PER_SECOND  (TICKS_PER_SECOND),
    .SETTLE_TICKS      (SETTLE_TICKS),
    .RETRY_DELAY_TICKS (RETRY_DELAY_TICKS)
  ) u_link_fsm (
    .tx_clock           (tx_clock),
    .rst_n              (rst_n),
    .config_ready       (config_ready),
    .phy_connected      (phy_connected),
    .static_ip          (static_ip),
    .local_mac          (local_mac),
    .dhcp_success       (dhcp_success),
    .ip_accept          (ip_accept),
    .lease              (lease),
    .state              (network_state),
    .local_ip           (local_ip),
    .phy_init_request   (phy_init_request),
    .dhcp_tx_enable     (dhcp_tx_enable),
    .dhcp_rx_enable     (dhcp_rx_enable),
    .dhcp_phase         (dhcp_phase),
    .dhcp_timeout       (dhcp_timeout),
    .static_ip_assigned (static_ip_assigned)
  );

  // ------------------------------------------------------------
  // transmit side
  // ------------------------------------------------------------
  tx_arbiter u_tx_arbiter (
    .tx_clock        (tx_clock),
    .rst_n           (rst_n),
    .arp_tx_request  (arp_tx_request),
    .icmp_tx_request (icmp_tx_request),
    .dhcp_tx_request (dhcp_tx_request),
    .udp_tx_request  (udp_tx_request),
    .dhcp_phase      (dhcp_phase),
    .link_tx_active  (link_tx_active),
    .tx_protocol     (tx_protocol),
    .arp_tx_enable   (arp_tx_enable),
    .icmp_tx_enable  (icmp_tx_enable),
    .udp_tx_enable   (udp_tx_enable)
  );

  udp_dest_select u_udp_dest_select (
    .tx_clock   (tx_clock),
    .rst_n      (rst_n),
    .run        (run),
    .dhcp_phase (dhcp_phase),
    .live_ip    (live_ip),
    .live_mac   (live_mac),
    .live_port  (live_port),
    .dhcp_ip    (dhcp_ip),
    .dhcp_mac   (dhcp_mac),
    .dhcp_port  (dhcp_port),
    .dest_ip    (dest_ip),
    .dest_mac   (dest_mac),
    .dest_port  (dest_port),
    .local_port (local_port)
  );

endmodule

// File: power_up_timer.sv
// power-up sequencer releasing the phy reset and then flagging configuration ready
`timescale 1ns/1ps

module power_up_timer #(
  parameter int POWER_UP_BITS = 15
) (
  input  logic tx_clock,
  input  logic rst_n,
  output logic phy_reset_n,
  output logic config_ready
);

  logic [POWER_UP_BITS-1:0] count;

  // counts up once per cycle, sticks at all ones
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!(&count)) begin
      count <= count + 1'b1;
    end
  end

  // top three bits release the phy
  assign phy_reset_n  = &count[POWER_UP_BITS-1 -: 3];
  // top four bits come later, config data valid
  assign config_ready = &count[POWER_UP_BITS-1 -: 4];

  // phy must be out of reset before config is read
  a_cfg_after_phy: assert property (
    @(posedge tx_clock) disable iff (!rst_n)
    $rose(config_ready) |-> phy_reset_n
  );

endmodule

// File: tb_network.sv
// testbench for the network control core with a cycle model, random traffic and a watchdog
`timescale 1ns/1ps

module tb_network import net_pkg::*; ();

  localparam int          TPS       = 20;
  localparam int          SETTLE    = 5;
  localparam int          RETRY     = 3;
  localparam int          PUB       = 6;
  localparam mac_addr_t   MAC_BASE  = 48'h02_12_34_56_78_9a;
  localparam int          CLK_NS    = 20;
  // release points of the power-up counter
  localparam int          PHY_AT    = 7 << (PUB - 3);
  localparam int          CFG_AT    = 15 << (PUB - 4);
  // scenario lengths in cycles
  localparam int          PWR_CYC   = (2 ** PUB) + SETTLE + 20;
  localparam int          DHCP_CYC  = 16 * (TPS + 1) + 4 * (RETRY + 2) + SETTLE + 20;
  localparam int          LEASE_CYC = 3 * (TPS + 1) + SETTLE + 20;
  localparam int          LOSS_CYC  = 6 * 40;
  localparam int          ARB_CYC   = 300;
  localparam longint      WATCHDOG_NS =
    2 * (PWR_CYC + DHCP_CYC + LEASE_CYC + LOSS_CYC + ARB_CYC) * CLK_NS;

  logic tx_clock, rst_n, macbit, phy_connected, dhcp_success, run;
  logic arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request, link_tx_active;
  ip_addr_t   static_ip, ip_accept, live_ip, dhcp_ip, local_ip, dest_ip;
  lease_t     lease;
  mac_addr_t  live_mac, dhcp_mac, local_mac, dest_mac, exp_mac;
  udp_port_t  live_port, dhcp_port, dest_port, local_port;
  logic       phy_reset_n, config_ready, phy_init_request, dhcp_tx_enable, dhcp_rx_enable;
  logic       dhcp_phase, dhcp_timeout, static_ip_assigned;
  logic       arp_tx_enable, icmp_tx_enable, udp_tx_enable;
  net_state_t network_state;
  tx_proto_t  tx_protocol;

  // ------------------------------------------------------------
  // model state
  // ------------------------------------------------------------
  net_state_t           m_state;
  ip_addr_t             m_local_ip, m_hold_ip;
  mac_addr_t            m_hold_mac;
  udp_port_t            m_hold_port;
  int unsigned          m_settle, m_timer;
  dhcp_sec_t            m_sec;
  renew_cnt_t           m_lease;
  logic                 m_tx_en, m_rx_en, m_ready, m_start;
  tx_proto_t            m_proto;
  logic [PUB-1:0]       m_pwr;

  integer seed;
  int     tx_pulses, init_pulses;

  network_top #(
    .TICKS_PER_SECOND (TPS), .SETTLE_TICKS (SETTLE), .RETRY_DELAY_TICKS (RETRY),
    .POWER_UP_BITS (PUB), .MAC_BASE (MAC_BASE)
  ) DUT (
    .tx_clock (tx_clock), .rst_n (rst_n), .macbit (macbit), .phy_connected (phy_connected),
    .static_ip (static_ip), .dhcp_success (dhcp_success), .ip_accept (ip_accept),
    .lease (lease), .arp_tx_request (arp_tx_request), .icmp_tx_request (icmp_tx_request),
    .dhcp_tx_request (dhcp_tx_request), .udp_tx_request (udp_tx_request),
    .link_tx_active (link_tx_active), .run (run), .live_ip (live_ip), .live_mac (live_mac),
    .live_port (live_port), .dhcp_ip (dhcp_ip), .dhcp_mac (dhcp_mac),
    .dhcp_port (dhcp_port), .phy_reset_n (phy_reset_n), .config_ready (config_ready),
    .network_state (network_state), .local_ip (local_ip), .local_mac (local_mac),
    .phy_init_request (phy_init_request), .dhcp_tx_enable (dhcp_tx_enable),
    .dhcp_rx_enable (dhcp_rx_enable), .dhcp_phase (dhcp_phase),
    .dhcp_timeout (dhcp_timeout), .static_ip_assigned (static_ip_assigned),
    .tx_protocol (tx_protocol), .arp_tx_enable (arp_tx_enable),
    .icmp_tx_enable (icmp_tx_enable), .udp_tx_enable (udp_tx_enable),
    .dest_ip (dest_ip), .dest_mac (dest_mac), .dest_port (dest_port),
    .local_port (local_port)
  );

  // strap low sets bit 1, strap high clears it
  assign exp_mac = macbit ? (MAC_BASE & ~48'h2) : (MAC_BASE | 48'h2);

  initial begin
    tx_clock = 1'b0;
    forever #(CLK_NS / 2) tx_clock = ~tx_clock;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the run took longer than all scenarios together");
    abort_run();
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopping simulation");
  endtask

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_state(string name, net_state_t got, net_state_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ip(string name, ip_addr_t got, ip_addr_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mac(string name, mac_addr_t got, mac_addr_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_proto(string name, tx_proto_t got, tx_proto_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_port(string name, udp_port_t got, udp_port_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------
  // cycle model, advanced on the rising edge
  // ------------------------------------------------------------
  task automatic reset_model();
    m_state    = ST_START;
    m_local_ip = '0;
    m_settle   = 0;
    m_timer    = 0;
    m_sec      = '0;
    m_lease    = '0;
    m_tx_en    = 1'b0;
    m_rx_en    = 1'b0;
    m_ready    = 1'b0;
    m_start    = 1'b0;
    m_proto    = PT_ARP;
    m_pwr      = '0;
    m_hold_ip  = '0;
    m_hold_mac = '0;
    m_hold_port = '0;
  endtask

  task automatic step_model();
    logic phase, lost, cfg, sec_done, retry, expired, st_ok;
    phase    = (m_state == ST_DHCP_REQUEST) || (m_state == ST_DHCP);
    lost     = (m_state > ST_PHY_CONNECT) && !phy_connected;
    cfg      = (m_pwr >= CFG_AT);
    sec_done = (m_state == ST_DHCP) && (m_timer == 0);
    retry    = sec_done && ((m_sec == 0) || (m_sec == 2) || (m_sec == 6));
    expired  = (m_lease == '0);
    st_ok    = (static_ip != 32'hffff_ffff) && (static_ip != 32'h0);
    // arbiter, link busy drops ready and start
    if (link_tx_active) begin
      m_ready = 1'b0;
      m_start = 1'b0;
    end else if (m_ready) begin
      m_start = 1'b1;
    end else if (arp_tx_request) begin
      m_proto = PT_ARP;
      m_ready = 1'b1;
    end else if (icmp_tx_request) begin
      m_proto = PT_ICMP;
      m_ready = 1'b1;
    end else if (phase ? dhcp_tx_request : udp_tx_request) begin
      m_proto = phase ? PT_DHCP : PT_UDP;
      m_ready = 1'b1;
    end
    if (!run) begin
      m_hold_ip   = live_ip;
      m_hold_mac  = live_mac;
      m_hold_port = live_port;
    end
    if (m_pwr != '1) m_pwr = m_pwr + 1'b1;
    // renewal countdown
    if (!lost && (m_state == ST_DHCP) && (dhcp_success || retry)) begin
      if (!dhcp_success) m_lease = RETRY;
      else if (lease == 0) m_lease = renew_cnt_t'(43200) * TPS;
      else m_lease = renew_cnt_t'(lease) * TPS / 2;
    end else if ((m_state == ST_DHCP_RENEW) && !expired) begin
      m_lease = m_lease - 1'b1;
    end
    m_tx_en = 1'b0;
    if (lost) begin
      m_state = ST_PHY_CONNECT;
    end else begin
      case (m_state)
        ST_START:        m_state = ST_CONFIG_START;
        ST_CONFIG_START: m_state = ST_CONFIG_WAIT;
        ST_CONFIG_WAIT: if (cfg) begin
          m_local_ip = static_ip;
          m_timer    = TPS;
          m_sec      = '0;
          m_state    = ST_PHY_INIT;
        end
        ST_PHY_INIT:     m_state = ST_PHY_CONNECT;
        ST_PHY_CONNECT: if (phy_connected) begin
          m_settle = SETTLE;
          m_state  = ST_PHY_SETTLE;
        end
        ST_PHY_SETTLE: begin
          if (m_settle != 0) m_settle--;
          else if (st_ok) m_state = ST_RUNNING;
          else begin
            m_local_ip = '0;
            m_state    = ST_DHCP_REQUEST;
          end
        end
        ST_DHCP_REQUEST: begin
          m_tx_en = 1'b1;
          m_rx_en = 1'b1;
          m_state = ST_DHCP;
        end
        ST_DHCP: begin
          if (dhcp_success) begin
            m_local_ip = ip_accept;
            m_timer    = TPS;
            m_sec      = '0;
            m_state    = ST_DHCP_RENEW;
          end else if (sec_done) begin
            m_timer = TPS;
            if (retry) m_state = ST_DHCP_RENEW;
            else if (m_sec == 4'd14) begin
              // link-local fallback, 169.254 plus low half of the mac
              m_local_ip = {16'ha9fe, exp_mac[15:0]};
              m_state    = ST_RUNNING;
            end
            m_sec = m_sec + 1'b1;
          end else begin
            m_timer--;
          end
        end
        ST_DHCP_RENEW: begin
          m_rx_en = 1'b0;
          if (expired) m_state = ST_DHCP_REQUEST;
        end
        default:         m_rx_en = 1'b0;
      endcase
    end
  endtask

  always @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) reset_model();
    else step_model();
  end

  // ------------------------------------------------------------
  // per-cycle compare and stimulus, all on the falling edge
  // ------------------------------------------------------------
  task automatic check_outputs();
    logic      phase;
    ip_addr_t  e_ip;
    mac_addr_t e_mac;
    udp_port_t e_port;
    phase = (m_state == ST_DHCP_REQUEST) || (m_state == ST_DHCP);
    check_bit("phy_reset_n", phy_reset_n, m_pwr >= PHY_AT);
    check_bit("config_ready", config_ready, m_pwr >= CFG_AT);
    check_state("network_state", network_state, m_state);
    check_ip("local_ip", local_ip, m_local_ip);
    check_mac("local_mac", local_mac, exp_mac);
    check_bit("phy_init_request", phy_init_request, m_state == ST_PHY_INIT);
    check_bit("dhcp_tx_enable", dhcp_tx_enable, m_tx_en);
    check_bit("dhcp_rx_enable", dhcp_rx_enable, m_rx_en);
    check_bit("dhcp_phase", dhcp_phase, phase);
    check_bit("dhcp_timeout", dhcp_timeout, m_sec == 4'd15);
    check_bit("static_ip_assigned", static_ip_assigned,
              (static_ip != 32'hffff_ffff) && (static_ip != 32'h0));
    if (m_ready || m_start) check_proto("tx_protocol", tx_protocol, m_proto);
    check_bit("arp_tx_enable", arp_tx_enable, m_start && (m_proto == PT_ARP));
    check_bit("icmp_tx_enable", icmp_tx_enable, m_start && (m_proto == PT_ICMP));
    check_bit("udp_tx_enable", udp_tx_enable,
              m_start && ((m_proto == PT_UDP) || (m_proto == PT_DHCP)));
    // server first, frozen target while running, else live
    if (phase) begin
      e_ip   = dhcp_ip;
      e_mac  = dhcp_mac;
      e_port = dhcp_port;
    end else if (run) begin
      e_ip   = m_hold_ip;
      e_mac  = m_hold_mac;
      e_port = m_hold_port;
    end else begin
      e_ip   = live_ip;
      e_mac  = live_mac;
      e_port = live_port;
    end
    check_ip("dest_ip", dest_ip, e_ip);
    check_mac("dest_mac", dest_mac, e_mac);
    check_port("dest_port", dest_port, e_port);
    check_port("local_port", local_port, phase ? 16'd68 : 16'd1024);
  endtask

  task automatic drive_traffic();
    arp_tx_request  = ($random(seed) & 3) == 0;
    icmp_tx_request = ($random(seed) & 3) == 0;
    dhcp_tx_request = ($random(seed) & 1) == 0;
    udp_tx_request  = ($random(seed) & 1) == 0;
    link_tx_active  = ($random(seed) & 3) == 0;
    if (($random(seed) & 7) == 0) run = !run;
    live_ip   = $random(seed);
    live_mac  = {$random(seed), $random(seed)};
    live_port = $random(seed);
    dhcp_ip   = $random(seed);
    dhcp_mac  = {$random(seed), $random(seed)};
    dhcp_port = $random(seed);
  endtask

  task automatic tick();
    @(negedge tx_clock);
    check_outputs();
    if (dhcp_tx_enable) tx_pulses++;
    if (phy_init_request) init_pulses++;
    drive_traffic();
  endtask

  task automatic wait_state(net_state_t target, int limit, string what);
    int n;
    n = 0;
    while (network_state !== target) begin
      if (n >= limit) begin
        $display("Timed out after %0d cycles waiting for %s", limit, what);
        abort_run();
      end
      tick();
      n++;
    end
  endtask

  // ------------------------------------------------------------
  // scenarios
  // ------------------------------------------------------------
  initial begin
    int         n;
    int         delay;
    net_state_t prev;
    seed = 32'h86ad;
    tx_pulses = 0;
    init_pulses = 0;
    rst_n = 1'b0;
    phy_connected = 1'b0;
    dhcp_success = 1'b0;
    run = 1'b0;
    static_ip = '0;
    ip_accept = '0;
    lease = '0;
    arp_tx_request = 1'b0;
    icmp_tx_request = 1'b0;
    dhcp_tx_request = 1'b0;
    udp_tx_request = 1'b0;
    link_tx_active = 1'b0;
    live_ip = '0;
    live_mac = '0;
    live_port = '0;
    dhcp_ip = '0;
    dhcp_mac = '0;
    dhcp_port = '0;
    macbit = $random(seed) & 1;
    repeat (2) tick();
    // power-up then static address
    do static_ip = $random(seed); while ((static_ip == '0) || (static_ip == '1));
    phy_connected = 1'b1;
    rst_n = 1'b1;
    wait_state(ST_RUNNING, PWR_CYC, "static address");
    check_ip("local_ip", local_ip, static_ip);
    if (init_pulses != 1) begin
      $display("phy_init_request pulsed %0d times instead of once", init_pulses);
      abort_run();
    end
    // no dhcp reply, retries then link-local
    static_ip = '0;
    phy_connected = 1'b0;
    tick();
    check_state("network_state", network_state, ST_PHY_CONNECT);
    phy_connected = 1'b1;
    tx_pulses = 0;
    wait_state(ST_RUNNING, DHCP_CYC, "link-local fallback");
    if (tx_pulses != 4) begin
      $display("dhcp_tx_enable pulsed %0d times, four requests were due", tx_pulses);
      abort_run();
    end
    check_bit("dhcp_timeout", dhcp_timeout, 1'b1);
    check_ip("local_ip", local_ip, {16'ha9fe, exp_mac[15:0]});
    // dhcp reply with a short lease
    phy_connected = 1'b0;
    tick();
    phy_connected = 1'b1;
    wait_state(ST_DHCP, LEASE_CYC, "dhcp wait state");
    repeat ($random(seed) & 3) tick();
    ip_accept    = $random(seed);
    lease        = 1 + ($random(seed) & 3);
    dhcp_success = 1'b1;
    tick();
    dhcp_success = 1'b0;
    check_state("network_state", network_state, ST_DHCP_RENEW);
    check_ip("local_ip", local_ip, ip_accept);
    n = 0;
    while (network_state == ST_DHCP_RENEW) begin
      if (n > LEASE_CYC) begin
        $display("Lease renewal never expired");
        abort_run();
      end
      n++;
      tick();
    end
    check_state("network_state", network_state, ST_DHCP_REQUEST);
    if (n != lease * TPS / 2 + 1) begin
      $display("Renew state lasted %0d cycles, lease of %0d s wanted %0d", n, lease,
               lease * TPS / 2 + 1);
      abort_run();
    end
    // link drops at random points
    repeat (6) begin
      delay = 1 + ($random(seed) & 31);
      repeat (delay) tick();
      prev = network_state;
      phy_connected = 1'b0;
      tick();
      if (prev > ST_PHY_CONNECT) check_state("network_state", network_state, ST_PHY_CONNECT);
      phy_connected = 1'b1;
    end
    // arbiter and destination soak
    repeat (ARB_CYC) tick();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: tx_arbiter.sv
// fixed-priority transmit arbiter choosing arp, icmp or udp/dhcp for the shared tx path
`timescale 1ns/1ps

module tx_arbiter import net_pkg::*; (
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      arp_tx_request,
  input  logic      icmp_tx_request,
  input  logic      dhcp_tx_request,
  input  logic      udp_tx_request,
  input  logic      dhcp_phase,
  input  logic      link_tx_active,
  output tx_proto_t tx_protocol,
  output logic      arp_tx_enable,
  output logic      icmp_tx_enable,
  output logic      udp_tx_enable
);

  logic tx_ready;
  logic tx_start;
  // dhcp owns the udp sender during the dhcp phase
  logic dhcp_udp_request;

  assign dhcp_udp_request = dhcp_phase ? dhcp_tx_request : udp_tx_request;

  // ready one cycle, start the next
  // link busy drops both
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      tx_ready    <= 1'b0;
      tx_start    <= 1'b0;
      tx_protocol <= PT_ARP;
    end else if (link_tx_active) begin
      tx_ready <= 1'b0;
      tx_start <= 1'b0;
    end else if (tx_ready) begin
      tx_start <= 1'b1;
    end else if (arp_tx_request) begin
      tx_protocol <= PT_ARP;
      tx_ready    <= 1'b1;
    end else if (icmp_tx_request) begin
      tx_protocol <= PT_ICMP;
      tx_ready    <= 1'b1;
    end else if (dhcp_udp_request) begin
      tx_protocol <= dhcp_phase ? PT_DHCP : PT_UDP;
      tx_ready    <= 1'b1;
    end
  end

  // udp sender carries both dhcp and data frames
  assign arp_tx_enable  = tx_start && (tx_protocol == PT_ARP);
  assign icmp_tx_enable = tx_start && (tx_protocol == PT_ICMP);
  assign udp_tx_enable  = tx_start && ((tx_protocol == PT_UDP) || (tx_protocol == PT_DHCP));

  a_one_enable: assert property (
    @(posedge tx_clock) disable iff (!rst_n)
    $onehot0({arp_tx_enable, icmp_tx_enable, udp_tx_enable})
  );

endmodule

// File: udp_dest_select.sv
// udp destination mux routing dhcp to the server and freezing the stream target while running
`timescale 1ns/1ps

module udp_dest_select import net_pkg::*; (
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      run,
  input  logic      dhcp_phase,
  input  ip_addr_t  live_ip,
  input  mac_addr_t live_mac,
  input  udp_port_t live_port,
  input  ip_addr_t  dhcp_ip,
  input  mac_addr_t dhcp_mac,
  input  udp_port_t dhcp_port,
  output ip_addr_t  dest_ip,
  output mac_addr_t dest_mac,
  output udp_port_t dest_port,
  output udp_port_t local_port
);

  ip_addr_t  hold_ip;
  mac_addr_t hold_mac;
  udp_port_t hold_port;

  // track the live target until run goes high
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      hold_ip   <= '0;
      hold_mac  <= '0;
      hold_port <= '0;
    end else if (!run) begin
      hold_ip   <= live_ip;
      hold_mac  <= live_mac;
      hold_port <= live_port;
    end
  end

  // dhcp first, then held, then live
  always_comb begin
    if (dhcp_phase) begin
      dest_ip   = dhcp_ip;
      dest_mac  = dhcp_mac;
      dest_port = dhcp_port;
    end else if (run) begin
      dest_ip   = hold_ip;
      dest_mac  = hold_mac;
      dest_port = hold_port;
    end else begin
      dest_ip   = live_ip;
      dest_mac  = live_mac;
      dest_port = live_port;
    end
  end

  assign local_port = dhcp_phase ? DHCP_CLIENT_PORT : DATA_CLIENT_PORT;

  // stream target must not move mid-run
  a_run_frozen: assert property (
    @(posedge tx_clock) disable iff (!rst_n)
    (run && $past(run) && !dhcp_phase && !$past(dhcp_phase)) |->
      ($stable(dest_ip) && $stable(dest_mac) && $stable(dest_port))
  );

endmodule
